/* Bender.yml */
package:
  name: fp_pipe

sources:
  - files:
      - design/fp_pipe_pkg.sv
      - design/reg_file_2r1w.sv
      - design/fp_forward_unit.sv
      - design/fp_exec_unit.sv
      - design/fp_pipe_stages.sv
      - design/fp_pipe_top.sv
  - target: test
    files:
      - tb/fp_pipe_properties.sv
      - tb/fp_pipe_tb.sv

/* design/fp_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_exec_unit (
	input  fp_pipe_pkg::idex_t  idex,
	input  fp_pipe_pkg::stage_t ex_mem,
	input  fp_pipe_pkg::stage_t mem_wb,
	input  fp_pipe_pkg::fwd_a_e fwd_a,
	input  fp_pipe_pkg::fwd_b_e fwd_b,
	output fp_pipe_pkg::stage_t ex_result
);
	import fp_pipe_pkg::*;

	fp_word_u op_a;
	fp_word_u op_b;
	fp_word_u res;
	logic     a_lt_b;
	logic     both_zero;
	logic     int_dest;

	// Operand A, register value comes from the int file for the i2f move
	always_comb begin
		case (fwd_a)
			SRC_EX_FP, SRC_EX_INT: op_a = ex_mem.result;
			SRC_MEM_FP, SRC_MEM_INT: op_a = mem_wb.result;
			default: op_a.raw = (idex.op == OP_FMV_W_X) ? idex.int_a : idex.fp_a.raw;
		endcase
	end

	always_comb begin
		case (fwd_b)
			SRC_B_EX_FP: op_b = ex_mem.result;
			SRC_B_MEM_FP: op_b = mem_wb.result;
			default: op_b = idex.fp_b;
		endcase
	end

	// Sign first, so -0 sorts before +0
	always_comb begin
		if (op_a.f.sign != op_b.f.sign)
			a_lt_b = op_a.f.sign;
		else if (op_a.f.sign)
			a_lt_b = op_a.raw[30:0] > op_b.raw[30:0];
		else
			a_lt_b = op_a.raw[30:0] < op_b.raw[30:0];
	end

	assign both_zero = (op_a.raw[30:0] == '0) && (op_b.raw[30:0] == '0);

	always_comb begin
		res = op_a;
		case (idex.op)
			OP_FSGNJ:   res.f.sign = op_b.f.sign;
			OP_FSGNJN:  res.f.sign = ~op_b.f.sign;
			OP_FSGNJX:  res.f.sign = op_a.f.sign ^ op_b.f.sign;
			OP_FMIN:    res = a_lt_b ? op_a : op_b;
			OP_FMAX:    res = a_lt_b ? op_b : op_a;
			OP_FEQ:     res.raw = {31'd0, (op_a.raw == op_b.raw) || both_zero};
			OP_FMV_X_W: res.raw = op_a.raw;
			OP_FMV_W_X: res.raw = op_a.raw;
			OP_LI:      res.raw = idex.imm;
			default:    res.raw = '0;
		endcase
	end

	assign int_dest = is_int_dest(idex.op);

	// Register 0 is never a real destination in either file
	always_comb begin
		ex_result.valid  = idex.valid;
		ex_result.op     = idex.op;
		ex_result.rd     = idex.rd;
		ex_result.fp_wr  = !int_dest && (idex.rd != '0);
		ex_result.int_wr = int_dest && (idex.rd != '0);
		ex_result.result = res;
	end

endmodule

`default_nettype wire

/* design/fp_forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_forward_unit (
	input  fp_pipe_pkg::idex_t  idex,
	input  fp_pipe_pkg::stage_t ex_mem,
	input  fp_pipe_pkg::stage_t mem_wb,
	output fp_pipe_pkg::fwd_a_e fwd_a,
	output fp_pipe_pkg::fwd_b_e fwd_b
);
	import fp_pipe_pkg::*;

	logic fp_op_id_ex;
	logic i2f_op_id_ex;
	logic fforw_detect;
	logic i2fforw_detect;
	logic ex_dest_x0;
	logic mem_dest_x0;

	assign fp_op_id_ex  = idex.valid && is_fp_src(idex.op);
	assign i2f_op_id_ex = idex.valid && (idex.op == OP_FMV_W_X);

	// Only worth looking further when some stage writes the matching file
	assign fforw_detect   = fp_op_id_ex && (ex_mem.fp_wr || mem_wb.fp_wr);
	assign i2fforw_detect = i2f_op_id_ex && (ex_mem.int_wr || mem_wb.int_wr);

	assign ex_dest_x0  = (ex_mem.rd == '0);
	assign mem_dest_x0 = (mem_wb.rd == '0);

	// Operand A, EX/MEM wins over MEM/WB
	always_comb begin
		fwd_a = SRC_REG;
		if (fforw_detect) begin
			if (ex_mem.fp_wr && !ex_dest_x0 && ex_mem.rd == idex.rs1) begin
				fwd_a = SRC_EX_FP;
			end else if (mem_wb.fp_wr && !mem_dest_x0 && mem_wb.rd == idex.rs1) begin
				fwd_a = SRC_MEM_FP;
			end
		end else if (i2fforw_detect) begin
			if (ex_mem.int_wr && !ex_dest_x0 && ex_mem.rd == idex.rs1) begin
				fwd_a = SRC_EX_INT;
			end else if (mem_wb.int_wr && !mem_dest_x0 && mem_wb.rd == idex.rs1) begin
				fwd_a = SRC_MEM_INT;
			end
		end
	end

	// Operand B, fp producers only
	always_comb begin
		fwd_b = SRC_B_REG;
		if (fforw_detect) begin
			if (ex_mem.fp_wr && !ex_dest_x0 && ex_mem.rd == idex.rs2) begin
				fwd_b = SRC_B_EX_FP;
			end else if (mem_wb.fp_wr && !mem_dest_x0 && mem_wb.rd == idex.rs2) begin
				fwd_b = SRC_B_MEM_FP;
			end
		end
	end

endmodule

`default_nettype wire

/* design/fp_pipe_pkg.sv */
`default_nettype none

package fp_pipe_pkg;

	localparam int NUM_REGS = 32;

	typedef logic [4:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_FSGNJ   = 4'd0,
		OP_FSGNJN  = 4'd1,
		OP_FSGNJX  = 4'd2,
		OP_FMIN    = 4'd3,
		OP_FMAX    = 4'd4,
		OP_FEQ     = 4'd5,
		OP_FMV_X_W = 4'd6,
		OP_FMV_W_X = 4'd7,
		OP_LI      = 4'd8
	} fp_op_e;

	// Operand A sources, same codes as the integer pipe's forward unit
	typedef enum logic [2:0] {
		SRC_REG     = 3'b000,
		SRC_MEM_FP  = 3'b001,
		SRC_EX_FP   = 3'b010,
		SRC_EX_INT  = 3'b011,
		SRC_MEM_INT = 3'b100
	} fwd_a_e;

	// Operand B only ever forwards from fp producers
	typedef enum logic [1:0] {
		SRC_B_REG    = 2'b00,
		SRC_B_MEM_FP = 2'b01,
		SRC_B_EX_FP  = 2'b10
	} fwd_b_e;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] mant;
	} fp_fields_t;

	typedef union packed {
		logic [31:0] raw;
		fp_fields_t  f;
	} fp_word_u;

	typedef struct packed {
		logic        valid;
		fp_op_e      op;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		reg_idx_t    rd;
		logic [31:0] imm;
	} issue_t;

	typedef struct packed {
		logic     valid;
		fp_op_e   op;
		reg_idx_t rd;
		logic     fp_wr;
		logic     int_wr;
		fp_word_u result;
	} stage_t;

	typedef struct packed {
		logic        valid;
		fp_op_e      op;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [31:0] imm;
		fp_word_u    fp_a;
		fp_word_u    fp_b;
		logic [31:0] int_a;
	} idex_t;

	typedef struct packed {
		logic        valid;
		logic        int_wr;
		reg_idx_t    rd;
		logic [31:0] data;
	} retire_t;

	// Ops whose result lands in the integer file
	function automatic logic is_int_dest(fp_op_e op);
		return (op == OP_FEQ) || (op == OP_FMV_X_W) || (op == OP_LI);
	endfunction

	// Ops that read fp registers on rs1
	function automatic logic is_fp_src(fp_op_e op);
		return (op != OP_FMV_W_X) && (op != OP_LI);
	endfunction

endpackage

`default_nettype wire

/* design/fp_pipe_stages.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_pipe_stages (
	input  logic                 clk,
	input  logic                 arst_n,
	input  fp_pipe_pkg::issue_t  issue,
	input  logic [31:0]          fp_rdata_a,
	input  logic [31:0]          fp_rdata_b,
	input  logic [31:0]          int_rdata_a,
	input  fp_pipe_pkg::stage_t  ex_result,
	output fp_pipe_pkg::idex_t   idex,
	output fp_pipe_pkg::stage_t  ex_mem,
	output fp_pipe_pkg::stage_t  mem_wb,
	output fp_pipe_pkg::retire_t retire
);
	import fp_pipe_pkg::*;

	idex_t  idex_d;
	stage_t ex_mem_d;

	// Operands are read while the instruction is on the issue port
	always_comb begin
		idex_d.valid = issue.valid;
		idex_d.op    = issue.op;
		idex_d.rd    = issue.rd;
		idex_d.rs1   = issue.rs1;
		idex_d.rs2   = issue.rs2;
		idex_d.imm   = issue.imm;
		idex_d.fp_a  = fp_word_u'(fp_rdata_a);
		idex_d.fp_b  = fp_word_u'(fp_rdata_b);
		idex_d.int_a = int_rdata_a;
	end

	// Write enables only survive with a valid instruction behind them
	always_comb begin
		ex_mem_d        = ex_result;
		ex_mem_d.fp_wr  = ex_result.valid && ex_result.fp_wr;
		ex_mem_d.int_wr = ex_result.valid && ex_result.int_wr;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			idex   <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			idex   <= idex_d;
			ex_mem <= ex_mem_d;
			mem_wb <= ex_mem;
		end
	end

	// int_wr on retire names the target file, even for rd 0
	assign retire = '{
		valid:  mem_wb.valid,
		int_wr: is_int_dest(mem_wb.op),
		rd:     mem_wb.rd,
		data:   mem_wb.result.raw
	};

endmodule

`default_nettype wire

/* design/fp_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_pipe_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  fp_pipe_pkg::issue_t  issue,
	output fp_pipe_pkg::retire_t retire
);
	import fp_pipe_pkg::*;

	logic [31:0] fp_rdata_a;
	logic [31:0] fp_rdata_b;
	logic [31:0] int_rdata_a;
	idex_t       idex;
	stage_t      ex_mem;
	stage_t      mem_wb;
	stage_t      ex_result;
	fwd_a_e      fwd_a;
	fwd_b_e      fwd_b;

	reg_file_2r1w u_fp_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.raddr_a (issue.rs1),
		.raddr_b (issue.rs2),
		.rdata_a (fp_rdata_a),
		.rdata_b (fp_rdata_b),
		.wen     (mem_wb.fp_wr),
		.waddr   (mem_wb.rd),
		.wdata   (mem_wb.result.raw)
	);

	// Only the i2f move reads the int file, on rs1
	reg_file_2r1w u_int_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.raddr_a (issue.rs1),
		.raddr_b (issue.rs2),
		.rdata_a (int_rdata_a),
		.rdata_b (),
		.wen     (mem_wb.int_wr),
		.waddr   (mem_wb.rd),
		.wdata   (mem_wb.result.raw)
	);

	fp_pipe_stages u_stages (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue       (issue),
		.fp_rdata_a  (fp_rdata_a),
		.fp_rdata_b  (fp_rdata_b),
		.int_rdata_a (int_rdata_a),
		.ex_result   (ex_result),
		.idex        (idex),
		.ex_mem      (ex_mem),
		.mem_wb      (mem_wb),
		.retire      (retire)
	);

	fp_forward_unit u_fwd (
		.idex   (idex),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b)
	);

	fp_exec_unit u_exec (
		.idex      (idex),
		.ex_mem    (ex_mem),
		.mem_wb    (mem_wb),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.ex_result (ex_result)
	);

endmodule

`default_nettype wire

/* design/reg_file_2r1w.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file_2r1w (
	input  logic                  clk,
	input  logic                  arst_n,
	input  fp_pipe_pkg::reg_idx_t raddr_a,
	input  fp_pipe_pkg::reg_idx_t raddr_b,
	output logic [31:0]           rdata_a,
	output logic [31:0]           rdata_b,
	input  logic                  wen,
	input  fp_pipe_pkg::reg_idx_t waddr,
	input  logic [31:0]           wdata
);
	import fp_pipe_pkg::*;

	logic [31:0] mem [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				mem[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			mem[waddr] <= wdata;
		end
	end

	// Write-through so a read in the write cycle sees the new value
	always_comb begin
		if (raddr_a == '0)
			rdata_a = '0;
		else if (wen && waddr == raddr_a)
			rdata_a = wdata;
		else
			rdata_a = mem[raddr_a];

		if (raddr_b == '0)
			rdata_b = '0;
		else if (wen && waddr == raddr_b)
			rdata_b = wdata;
		else
			rdata_b = mem[raddr_b];
	end

endmodule

`default_nettype wire

/* fp_pipe_top.f */
design/fp_pipe_pkg.sv
design/reg_file_2r1w.sv
design/fp_forward_unit.sv
design/fp_exec_unit.sv
design/fp_pipe_stages.sv
design/fp_pipe_top.sv
tb/fp_pipe_properties.sv
tb/fp_pipe_tb.sv

/* tb/fp_pipe_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_pipe_properties (
	input logic                 clk,
	input logic                 arst_n,
	input fp_pipe_pkg::issue_t  issue,
	input fp_pipe_pkg::retire_t retire,
	input fp_pipe_pkg::stage_t  ex_mem,
	input fp_pipe_pkg::stage_t  mem_wb,
	input fp_pipe_pkg::fwd_a_e  fwd_a,
	input fp_pipe_pkg::fwd_b_e  fwd_b
);
	import fp_pipe_pkg::*;

	int unsigned fail_count = 0;

	function automatic logic writes_int(fp_op_e op);
		return (op == OP_FEQ) || (op == OP_FMV_X_W) || (op == OP_LI);
	endfunction

	a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !retire.valid)
		else begin
			fail_count++;
			$error("retire.valid high during reset");
		end

	// Three edges from capture to the retire cycle
	a_retire_latency: assert property (@(posedge clk) disable iff (!arst_n)
		issue.valid |-> ##3 (retire.valid && retire.rd == $past(issue.rd, 3)
			&& retire.int_wr == writes_int($past(issue.op, 3))))
		else begin
			fail_count++;
			$error("retire missing or wrong three cycles after issue");
		end

	a_no_phantom_retire: assert property (@(posedge clk) disable iff (!arst_n)
		!issue.valid |-> ##3 !retire.valid)
		else begin
			fail_count++;
			$error("retire without a matching issue");
		end

	a_fwd_a_ex_rd: assert property (@(posedge clk) disable iff (!arst_n)
		(fwd_a == SRC_EX_FP || fwd_a == SRC_EX_INT) |-> ex_mem.rd != '0)
		else begin
			fail_count++;
			$error("fwd_a selects EX/MEM with rd 0");
		end

	a_fwd_a_mem_rd: assert property (@(posedge clk) disable iff (!arst_n)
		(fwd_a == SRC_MEM_FP || fwd_a == SRC_MEM_INT) |-> mem_wb.rd != '0)
		else begin
			fail_count++;
			$error("fwd_a selects MEM/WB with rd 0");
		end

	a_fwd_b_rd: assert property (@(posedge clk) disable iff (!arst_n)
		(fwd_b == SRC_B_EX_FP && ex_mem.rd == '0) || (fwd_b == SRC_B_MEM_FP && mem_wb.rd == '0)
			|-> 1'b0)
		else begin
			fail_count++;
			$error("fwd_b selects a stage with rd 0");
		end

endmodule

`default_nettype wire

/* tb/fp_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_pipe_tb;
	import fp_pipe_pkg::*;

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_INSTR    = 3000;
	localparam int FILL_INSTR   = 12;
	localparam int DRIVE_DELAY  = 2;

	logic        clk;
	logic        arst_n;
	issue_t      issue;
	retire_t     retire;

	int          seed = 73259;
	int unsigned errors = 0;
	int unsigned retired = 0;
	logic [31:0] fp_model [NUM_REGS];
	logic [31:0] int_model [NUM_REGS];
	retire_t     expected_q [$];

	fp_pipe_top u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue),
		.retire (retire)
	);

	bind fp_pipe_top fp_pipe_properties u_props (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue),
		.retire (retire),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((NUM_INSTR + 50) * PERIOD);
		$display("Timeout: the pipe did not retire every instruction in time");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic writes_int(fp_op_e op);
		return (op == OP_FEQ) || (op == OP_FMV_X_W) || (op == OP_LI);
	endfunction

	// Monotone key for sign-magnitude order, -0 lands just below +0
	function automatic logic [31:0] order_key(logic [31:0] v);
		return v[31] ? ~v : {1'b1, v[30:0]};
	endfunction

	function automatic logic [31:0] expected_result(fp_op_e op, logic [31:0] a,
			logic [31:0] b, logic [31:0] imm);
		logic [31:0] r;
		logic        zeros;
		zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
		case (op)
			OP_FSGNJ:   r = {b[31], a[30:0]};
			OP_FSGNJN:  r = {~b[31], a[30:0]};
			OP_FSGNJX:  r = {a[31] ^ b[31], a[30:0]};
			OP_FMIN:    r = (order_key(a) < order_key(b)) ? a : b;
			OP_FMAX:    r = (order_key(a) < order_key(b)) ? b : a;
			OP_FEQ:     r = ((a == b) || zeros) ? 32'd1 : 32'd0;
			OP_FMV_X_W: r = a;
			OP_FMV_W_X: r = a;
			OP_LI:      r = imm;
			default:    r = 32'd0;
		endcase
		return r;
	endfunction

	// Small register range keeps dependencies close together
	task automatic draw_instruction(input int idx, output issue_t ins);
		int unsigned pick;
		ins.valid = 1'b1;
		ins.rs1 = reg_idx_t'($unsigned($random(seed)) % 6);
		ins.rs2 = reg_idx_t'($unsigned($random(seed)) % 6);
		ins.rd = reg_idx_t'($unsigned($random(seed)) % 6);
		if (idx < FILL_INSTR) begin
			ins.op = (idx % 2 == 0) ? OP_LI : OP_FMV_W_X;
		end else begin
			pick = $unsigned($random(seed)) % 9;
			ins.op = fp_op_e'(pick[3:0]);
		end
		// Signed zeros and ones show up often
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: ins.imm = 32'h0000_0000;
			1: ins.imm = 32'h8000_0000;
			2: ins.imm = 32'h3f80_0000;
			3: ins.imm = 32'hbf80_0000;
			default: ins.imm = $random(seed);
		endcase
	endtask

	task automatic model_issue(input issue_t ins);
		logic [31:0] a;
		logic [31:0] b;
		retire_t     want;
		a = (ins.op == OP_FMV_W_X) ? int_model[ins.rs1] : fp_model[ins.rs1];
		b = fp_model[ins.rs2];
		want.valid = 1'b1;
		want.int_wr = writes_int(ins.op);
		want.rd = ins.rd;
		want.data = expected_result(ins.op, a, b, ins.imm);
		expected_q.push_back(want);
		if (ins.rd != '0) begin
			if (want.int_wr)
				int_model[ins.rd] = want.data;
			else
				fp_model[ins.rd] = want.data;
		end
	endtask

	task automatic check_retire();
		retire_t want;
		if (expected_q.size() == 0) begin
			errors++;
			$display("Unexpected retire with nothing outstanding, rd %0d", retire.rd);
		end else begin
			want = expected_q.pop_front();
			retired++;
			assert (retire.rd == want.rd) else begin
				errors++;
				$display("Fail retire.rd: got %h expected %h", retire.rd, want.rd);
			end
			assert (retire.int_wr == want.int_wr) else begin
				errors++;
				$display("Fail retire.int_wr: got %h expected %h", retire.int_wr, want.int_wr);
			end
			assert (retire.data == want.data) else begin
				errors++;
				$display("Fail retire.data: got %h expected %h", retire.data, want.data);
			end
		end
	endtask

	// Retire is registered, mid-cycle it is settled
	always @(negedge clk) begin
		if (arst_n && retire.valid) begin
			check_retire();
		end
	end

	initial begin
		issue_t ins;
		arst_n = 1'b0;
		issue = '0;
		for (int r = 0; r < NUM_REGS; r++) begin
			fp_model[r] = 32'd0;
			int_model[r] = 32'd0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		for (int i = 0; i < NUM_INSTR; i++) begin
			draw_instruction(i, ins);
			@(posedge clk);
			#DRIVE_DELAY;
			issue = ins;
			model_issue(ins);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		issue = '0;

		// Drain, the watchdog bounds this
		while (expected_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);

		$display("Errors: %0d retire checks, %0d assertions, %0d of %0d retired",
			errors, u_dut.u_props.fail_count, retired, NUM_INSTR);
		if (errors == 0 && u_dut.u_props.fail_count == 0 && retired == NUM_INSTR) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
